// ==== Makefile ====
TOP = tb_mem_stage
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/store_format.sv
verilog/lsu_issue.sv
verilog/load_align.sv
verilog/mem_stage.sv
sim/tb_mem_stage.sv

// ==== sim/tb_mem_stage.sv ====
`include "lsu_config.svh"

module tb_mem_stage;
	timeunit 1ns;
	timeprecision 100ps;
	import lsu_pkg::*;

	logic      clk;
	logic      reset;
	logic      req_valid;
	logic      req_ready;
	mem_req_t  req;
	logic      bus_req_valid;
	logic      addr_ok;
	bus_req_t  bus_req;
	logic      data_ok;
	xlen_t     bus_rdata;
	logic      resp_valid;
	mem_resp_t resp;

	logic [7:0] mem [64];     // the low six address bits pick the byte of the bus memory
	mem_resp_t  exp_q [$];    // expected responses in request order
	xlen_t      rdata_q [$];  // word read at each address phase
	int         due_q [$];    // earliest cycle for each data phase
	int         cycle;
	int         outstanding;
	integer     seed;
	int         addr_mode;    // 0 random, 1 held low, 2 held high
	logic       hold_data;
	logic       stalled;
	bus_req_t   last_bus_req;
	logic       last_data_ok;
	logic       want_cacheable;
	string      test_name;
	int         test_errs;
	int         tests;
	int         failed;
	int         errors;
	xlen_t      far_addr [5];
	logic       far_cacheable [5];

	mem_stage dut_i (.*);

	always #50 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	task automatic begin_test(string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, test_errs);
			failed++;
		end
		tests++;
	endtask

	task automatic value_error(string what, logic [137:0] want, logic [137:0] got);
		$display("** Error %s: %s expected %0h actual %0h", test_name, what, want, got);
		test_errs++;
		errors++;
	endtask

	task automatic note_failure(string what);
		$display("test %s: %s", test_name, what);
		test_errs++;
		errors++;
	endtask

	task automatic fail_timeout(string what);
		$display("test %s: %s before the timeout", test_name, what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// the little endian bytes at addr and above extended to the full word
	function automatic xlen_t load_value(xlen_t addr, mem_size_t size, logic sign);
		int n;
		xlen_t v;
		n = 1 << size;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v[{3'(k), 3'b000} +: 8] = mem[addr[5:0] + 6'(k)];
		end
		if (sign && v[6'(8 * n - 1)]) begin
			v = v | ~((64'd1 << (8 * n)) - 64'd1);
		end
		return v;
	endfunction

	task automatic check_address_phase();
		int n;
		logic [2:0] lane;
		strb_t want_strb;
		n = 1 << req.size;
		want_strb = '0;
		for (int k = 0; k < n; k++) begin
			lane = req.addr[2:0] + 3'(k);
			want_strb[lane] = 1'b1;
			if (req.write) begin
				assert (bus_req.wdata[{lane, 3'b000} +: 8] == req.wdata[{3'(k), 3'b000} +: 8])
				else value_error("store lane", 138'(req.wdata[{3'(k), 3'b000} +: 8]),
					138'(bus_req.wdata[{lane, 3'b000} +: 8]));
			end
		end
		assert (bus_req.strb == want_strb)
		else value_error("strb", 138'(want_strb), 138'(bus_req.strb));
		assert (bus_req.addr == req.addr)
		else value_error("addr", 138'(req.addr), 138'(bus_req.addr));
		assert (bus_req.write == req.write)
		else value_error("write", 138'(req.write), 138'(bus_req.write));
		assert (bus_req.cacheable == want_cacheable)
		else value_error("cacheable", 138'(want_cacheable), 138'(bus_req.cacheable));
	endtask

	// the bus writes stores at the address phase and reads the word for the later data phase
	task automatic record_address_phase();
		logic [31:0] rnd;
		xlen_t word;
		mem_resp_t want;
		for (int j = 0; j < 8; j++) begin
			if (bus_req.write && bus_req.strb[3'(j)]) begin
				mem[{bus_req.addr[5:3], 3'(j)}] = bus_req.wdata[{3'(j), 3'b000} +: 8];
			end
			word[{3'(j), 3'b000} +: 8] = mem[{bus_req.addr[5:3], 3'(j)}];
		end
		want.write = req.write;
		want.rdata = req.write ? '0 : load_value(req.addr, req.size, req.sign);
		exp_q.push_back(want);
		rdata_q.push_back(word);
		rnd = $random(seed);
		due_q.push_back(cycle + 1 + int'(rnd[3:2]) % 3);
		outstanding++;
	endtask

	always @(posedge clk) begin
		logic [31:0] rnd;
		#5;
		rnd = $random(seed);
		case (addr_mode)
			0: addr_ok = rnd[1:0] != 2'b00;
			1: addr_ok = 1'b0;
			default: addr_ok = 1'b1;
		endcase
		if (!hold_data && due_q.size() > 0 && due_q[0] <= cycle) begin
			data_ok = 1'b1;   // one data phase per cycle keeps them in order
			bus_rdata = rdata_q[0];
		end else begin
			data_ok = 1'b0;
		end
	end

	always @(negedge clk) begin
		logic room;
		mem_resp_t want;
		room = outstanding < `LSU_MAX_OUTSTANDING || data_ok;
		if (reset) begin
			assert (!req_ready && !bus_req_valid && !resp_valid)
			else note_failure("handshake or response active during reset");
		end else begin
			assert (bus_req_valid == (req_valid && room))
			else value_error("bus_req_valid", 138'(req_valid && room), 138'(bus_req_valid));
			assert (req_ready == (addr_ok && room))
			else value_error("req_ready", 138'(addr_ok && room), 138'(req_ready));
			assert (resp_valid == last_data_ok)
			else value_error("resp_valid", 138'(last_data_ok), 138'(resp_valid));
			if (stalled) begin
				assert (bus_req == last_bus_req)
				else value_error("held bus_req", 138'(last_bus_req), 138'(bus_req));
			end
			stalled = bus_req_valid && !addr_ok;
			last_bus_req = bus_req;
			if (resp_valid) begin
				if (exp_q.size() == 0) begin
					note_failure("response without an accepted request");
				end else begin
					want = exp_q.pop_front();
					assert (resp == want)
					else value_error("resp", 138'(want), 138'(resp));
				end
			end
			if (data_ok) begin
				void'(rdata_q.pop_front());
				void'(due_q.pop_front());
				outstanding--;
			end
			if (bus_req_valid && addr_ok) begin
				check_address_phase();
				record_address_phase();
			end
		end
		last_data_ok = data_ok;
	end

	task automatic send(logic write, logic sign, mem_size_t size, xlen_t addr, xlen_t data);
		logic taken;
		req.write = write;
		req.sign = sign;
		req.size = size;
		req.addr = addr;
		req.wdata = data;
		req_valid = 1'b1;
		taken = 1'b0;
		for (int n = 0; n < 200 && !taken; n++) begin
			@(negedge clk);
			taken = req_ready;
			@(posedge clk);
			#5;
		end
		req_valid = 1'b0;
		if (!taken) begin
			fail_timeout("request was never accepted");
		end
	endtask

	task automatic set_bus(int mode, logic hold);
		@(negedge clk);
		addr_mode = mode;
		hold_data = hold;
		@(posedge clk);
		#5;
	endtask

	task automatic drain();
		for (int n = 0; n < 100 && (exp_q.size() > 0 || outstanding > 0); n++) begin
			@(posedge clk);
		end
		if (exp_q.size() > 0 || outstanding > 0) begin
			fail_timeout("responses still missing");
		end else begin
			@(posedge clk);
			#5;
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		addr_ok = 1'b0;
		data_ok = 1'b0;
		bus_rdata = '0;
		cycle = 0;
		outstanding = 0;
		seed = 39;
		addr_mode = 1;
		hold_data = 1'b0;
		stalled = 1'b0;
		last_bus_req = '0;
		last_data_ok = 1'b0;
		want_cacheable = 1'b0;
		tests = 0;
		failed = 0;
		errors = 0;
		far_addr = '{64'h7fff_fff8, 64'h8000_0000, 64'h8000_0010, 64'hffff_ffff_ffff_fff8, 64'h30};
		far_cacheable = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
		for (int i = 0; i < 64; i++) begin
			mem[i] = 8'(i * 29 + 131);   // every byte differs and some have the top bit set
		end

		begin_test("reset");
		repeat (16) @(posedge clk);
		#5;
		reset = 1'b0;
		@(negedge clk);
		assert (!req_ready && !bus_req_valid && !resp_valid)
		else note_failure("handshake or response active right after reset");
		set_bus(0, 1'b0);
		end_test();

		begin_test("store format");
		for (int s = 0; s < 4; s++) begin
			for (int off = 0; off < 8; off += 1 << s) begin
				send(1'b1, 1'b0, 2'(s), 64'(8 * s + off),
					64'h8899_aabb_ccdd_eeff ^ 64'(16 * s + off));
				send(1'b0, 1'b0, 2'(s), 64'(8 * s + off), '0);
			end
		end
		drain();
		end_test();

		begin_test("load extension");
		for (int s = 0; s < 4; s++) begin
			for (int sg = 0; sg < 2; sg++) begin
				for (int off = 0; off < 8; off += 1 << s) begin
					send(1'b0, 1'(sg), 2'(s), 64'(40 + off), '0);
				end
			end
		end
		drain();
		end_test();

		begin_test("back-pressure");
		set_bus(1, 1'b0);
		fork
			send(1'b0, 1'b1, 2'd2, 64'd20, '0);
			begin
				repeat (6) @(negedge clk);
				addr_mode = 0;
			end
		join
		send(1'b1, 1'b0, 2'd1, 64'd22, 64'h0000_0000_0000_beef);
		send(1'b0, 1'b1, 2'd1, 64'd22, '0);
		drain();
		end_test();

		begin_test("outstanding limit");
		set_bus(2, 1'b1);
		fork
			for (int i = 0; i <= `LSU_MAX_OUTSTANDING; i++) begin
				send(1'b0, 1'b0, 2'd3, 64'(8 * i), '0);
			end
			begin
				repeat (`LSU_MAX_OUTSTANDING + 4) @(negedge clk);
				hold_data = 1'b0;   // the held request goes out with the first data phase
			end
		join
		drain();
		set_bus(0, 1'b0);
		end_test();

		begin_test("cacheable");
		for (int i = 0; i < 5; i++) begin
			want_cacheable = far_cacheable[i];
			send(1'(i % 2), 1'b0, 2'd3, far_addr[i], 64'h0123_4567_89ab_cdef);
		end
		drain();
		end_test();

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog/load_align.sv ====
`include "lsu_config.svh"

module load_align (
	input  logic               clk,
	input  logic               reset,
	input  logic               data_ok,
	input  lsu_pkg::xlen_t     bus_rdata,
	input  lsu_pkg::inflight_t head,
	output logic               resp_valid,
	output lsu_pkg::mem_resp_t resp
);
	import lsu_pkg::*;

	localparam int XLEN = `LSU_XLEN;

	logic [5:0] bit_shift;
	xlen_t      shifted;
	xlen_t      extended;
	logic       fill;
	mem_resp_t  resp_next;

	assign bit_shift = {head.offset, 3'b000};
	assign shifted = bus_rdata >> bit_shift;   // bring the addressed lane down to byte zero

	always_comb begin
		fill = 1'b0;
		extended = shifted;
		case (head.size)
			2'd0: begin
				fill = head.sign & shifted[7];
				extended = {{(XLEN - 8){fill}}, shifted[7:0]};
			end
			2'd1: begin
				fill = head.sign & shifted[15];
				extended = {{(XLEN - 16){fill}}, shifted[15:0]};
			end
			2'd2: begin
				fill = head.sign & shifted[31];
				extended = {{(XLEN - 32){fill}}, shifted[31:0]};
			end
			default: begin
				extended = shifted;   // a full word needs no extension
			end
		endcase
	end

	always_comb begin
		resp_next.write = head.write;
		resp_next.rdata = head.write ? '0 : extended;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= data_ok;
		end
	end

	// writeback samples resp with the pulse, it holds until the next data phase
	always_ff @(posedge clk) begin
		if (data_ok) begin
			resp <= resp_next;
		end
	end

endmodule

// ==== verilog/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// width of a data word and of an address
`define LSU_XLEN 64

// address phases that may wait for their data phase at the same time
`define LSU_MAX_OUTSTANDING 2

// addresses at or above this go through the cached path
`define LSU_CACHEABLE_BASE 64'h0000_0000_8000_0000

`endif

// ==== verilog/lsu_issue.sv ====
`include "lsu_config.svh"

module lsu_issue (
	input  logic               clk,
	input  logic               reset,
	input  logic               req_valid,
	output logic               req_ready,
	input  lsu_pkg::mem_req_t  req,
	input  lsu_pkg::strb_t     strb,
	input  lsu_pkg::xlen_t     wdata,
	output logic               bus_req_valid,
	input  logic               addr_ok,
	output lsu_pkg::bus_req_t  bus_req,
	input  logic               data_ok,
	output lsu_pkg::inflight_t head
);
	import lsu_pkg::*;

	localparam int DEPTH = `LSU_MAX_OUTSTANDING;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	issue_state_e     state;
	issue_state_e     state_next;
	logic [CNT_W-1:0] count;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	inflight_t        queue [DEPTH];
	inflight_t        push_rec;
	logic             room;
	logic             push;
	logic             pop;

	// circular pointer step that also works for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	// a data phase ending this cycle frees a slot for a handshake in the same cycle
	assign room = (state != FULL) | data_ok;

	assign bus_req_valid = req_valid & room;
	assign req_ready = addr_ok & room;   // execute transfer and address handshake coincide

	assign push = bus_req_valid & addr_ok;
	assign pop = data_ok;                // the bus never signals data_ok with nothing outstanding

	always_comb begin
		bus_req.write = req.write;
		bus_req.cacheable = req.addr >= `LSU_CACHEABLE_BASE;
		bus_req.addr = req.addr;
		bus_req.strb = strb;
		bus_req.wdata = wdata;
	end

	// what the load aligner needs to know once the data comes back
	always_comb begin
		push_rec.write = req.write;
		push_rec.sign = req.sign;
		push_rec.size = req.size;
		push_rec.offset = req.addr[2:0];
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (push) begin
					state_next = (DEPTH == 1) ? FULL : BUSY;
				end
			end
			BUSY: begin
				if (push && !pop && count == CNT_W'(DEPTH - 1)) begin
					state_next = FULL;
				end else if (pop && !push && count == CNT_W'(1)) begin
					state_next = IDLE;
				end
			end
			FULL: begin
				if (pop && !push) begin
					state_next = (DEPTH == 1) ? IDLE : BUSY;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			count <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			state <= state_next;
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;   // both or neither leave the count alone
			endcase
		end
	end

	// when full, a push and a pop in one cycle share the slot, the head is read before it is overwritten
	always_ff @(posedge clk) begin
		if (push) begin
			queue[wr_ptr] <= push_rec;
		end
	end

	assign head = queue[rd_ptr];

endmodule

// ==== verilog/lsu_pkg.sv ====
`include "lsu_config.svh"

package lsu_pkg;

	typedef logic [`LSU_XLEN-1:0]   xlen_t;
	typedef logic [`LSU_XLEN/8-1:0] strb_t;   // one bit per byte lane
	typedef logic [1:0]             mem_size_t; // 0 byte, 1 half, 2 word, 3 double

	typedef struct packed {
		logic      write;
		logic      sign;
		mem_size_t size;
		xlen_t     addr;
		xlen_t     wdata;   // store data sits unshifted in the low bytes
	} mem_req_t;

	typedef struct packed {
		logic  write;
		logic  cacheable;
		xlen_t addr;
		strb_t strb;
		xlen_t wdata;       // already placed in its byte lanes
	} bus_req_t;

	typedef struct packed {
		logic      write;
		logic      sign;
		mem_size_t size;
		logic [2:0] offset;
	} inflight_t;

	typedef struct packed {
		logic  write;
		xlen_t rdata;       // zero for stores
	} mem_resp_t;

	typedef enum logic [1:0] {IDLE, BUSY, FULL} issue_state_e;

endpackage

// ==== verilog/mem_stage.sv ====
module mem_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               req_valid,
	output logic               req_ready,
	input  lsu_pkg::mem_req_t  req,
	output logic               bus_req_valid,
	input  logic               addr_ok,
	output lsu_pkg::bus_req_t  bus_req,
	input  logic               data_ok,
	input  lsu_pkg::xlen_t     bus_rdata,
	output logic               resp_valid,
	output lsu_pkg::mem_resp_t resp
);
	import lsu_pkg::*;

	strb_t     fmt_strb;
	xlen_t     fmt_wdata;
	inflight_t head;

	store_format format_i (
		.req   (req),
		.strb  (fmt_strb),
		.wdata (fmt_wdata)
	);

	lsu_issue issue_i (
		.clk           (clk),
		.reset         (reset),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.req           (req),
		.strb          (fmt_strb),
		.wdata         (fmt_wdata),
		.bus_req_valid (bus_req_valid),
		.addr_ok       (addr_ok),
		.bus_req       (bus_req),
		.data_ok       (data_ok),
		.head          (head)
	);

	// head is the oldest request still waiting for its data phase
	load_align align_i (
		.clk        (clk),
		.reset      (reset),
		.data_ok    (data_ok),
		.bus_rdata  (bus_rdata),
		.head       (head),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

endmodule

// ==== verilog/store_format.sv ====
module store_format (
	input  lsu_pkg::mem_req_t req,
	output lsu_pkg::strb_t    strb,
	output lsu_pkg::xlen_t    wdata
);
	import lsu_pkg::*;

	logic [2:0] offset;
	logic [5:0] bit_shift;
	strb_t      run;

	// the requester aligns the access, so the low bits are taken as given
	assign offset = req.addr[2:0];
	assign bit_shift = {offset, 3'b000};

	// a run of ones as long as the access, starting at lane zero
	always_comb begin
		case (req.size)
			2'd0: begin
				run = 8'h01;
			end
			2'd1: begin
				run = 8'h03;
			end
			2'd2: begin
				run = 8'h0f;
			end
			default: begin
				run = 8'hff;
			end
		endcase
	end

	// loads get a strobe as well, the bus uses it to pick the bytes read
	assign strb = run << offset;

	// move each store byte into the lane that its address selects
	assign wdata = req.wdata << bit_shift;

endmodule
